/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_icache
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
icache_pkg.sv
icache_way.sv
icache_fetch_pack.sv
icache_ctrl.sv
icache_top.sv
icache_props.sv
tb_icache.sv

/* icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl #(
    parameter int index_width = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    // pipeline side
    input  logic                     req_valid,
    input  icache_pkg::fetch_req_t   req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output logic                     op_ack,
    // way results
    input  logic                     hit0,
    input  logic                     hit1,
    // memory side
    input  logic                     mem_valid,
    output logic                     mem_req,
    output logic [31:0]              mem_addr,
    // way read control
    output logic                     rd_en,
    output logic [index_width-1:0]   rd_index,
    output logic [27-index_width:0]  cmp_tag,
    // way write control
    output logic                     fill_we0,
    output logic                     fill_we1,
    output logic                     inv_we,
    output logic [index_width-1:0]   wr_index,
    output logic [27-index_width:0]  wr_tag,
    // fetch combiner
    output logic                     sel_refill,
    output logic [31:0]              pc
);
    import icache_pkg::*;

    localparam int tag_width = 28 - index_width;
    localparam int num_sets = 1 << index_width;
    localparam int index_lsb = OFFSET_W + 2;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_LOOKUP = 2'd1;
    localparam logic [1:0] S_REFILL = 2'd2;

    logic [1:0]          state_q;
    logic [1:0]          state_d;
    fetch_req_t          req_q;
    // per set, the way to replace next
    logic [num_sets-1:0] lru_q;

    logic                accept;
    logic                lookup;
    logic                fetch_hit;
    logic                miss;
    logic                fill_done;
    logic                victim;

    ////////////////////////////////////////
    // decode of the current cycle
    ////////////////////////////////////////

    assign accept    = req_valid && req_ready;
    assign lookup    = (state_q == S_LOOKUP);
    assign fetch_hit = lookup && !req_q.inv && (hit0 || hit1);
    assign miss      = lookup && !req_q.inv && !(hit0 || hit1);
    assign fill_done = (state_q == S_REFILL) && mem_valid;
    assign victim    = lru_q[wr_index];

    // low from the miss lookup until the line comes back
    assign req_ready = (state_q == S_IDLE) || (lookup && !miss);
    assign rsp_valid = fetch_hit || fill_done;
    assign op_ack    = lookup && req_q.inv;

    assign mem_req  = (state_q == S_REFILL);
    assign mem_addr = {req_q.addr[31:index_lsb], {index_lsb{1'b0}}};

    // ways read the incoming set on acceptance
    assign rd_en    = accept;
    assign rd_index = req.addr[index_lsb +: index_width];
    assign cmp_tag  = req_q.addr[31 -: tag_width];

    assign wr_index = req_q.addr[index_lsb +: index_width];
    assign wr_tag   = req_q.addr[31 -: tag_width];
    assign fill_we0 = fill_done && !victim;
    assign fill_we1 = fill_done && victim;
    assign inv_we   = op_ack;

    assign sel_refill = (state_q == S_REFILL);
    assign pc         = req_q.addr;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (miss) begin
                    state_d = S_REFILL;
                end else if (accept) begin
                    state_d = S_LOOKUP;
                end else begin
                    state_d = S_IDLE;
                end
            end
            S_REFILL: begin
                if (mem_valid) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            // hit in way 0 makes way 1 the victim, and the reverse
            if (fetch_hit) begin
                lru_q[wr_index] <= hit0;
            end else if (fill_done) begin
                lru_q[wr_index] <= !victim;
            end
        end
    end

    // request held for lookup and refill
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

endmodule

/* icache_fetch_pack.sv */
`timescale 1ns/10ps

module icache_fetch_pack (
    input  icache_pkg::way_rd_t    way0,
    input  icache_pkg::way_rd_t    way1,
    input  icache_pkg::line_t      refill_line,
    input  logic                   sel_refill,
    input  logic [31:0]            pc,
    output icache_pkg::fetch_rsp_t rsp
);
    import icache_pkg::*;

    line_t               line_sel;
    logic [OFFSET_W-1:0] word_off;
    word_t               lo_word;
    word_t               hi_word;

    ////////////////////////////////////////
    // line select
    ////////////////////////////////////////

    // the returning line goes straight out during refill
    always_comb begin
        if (sel_refill) begin
            line_sel = refill_line;
        end else if (way1.hit) begin
            line_sel = way1.line;
        end else begin
            line_sel = way0.line;
        end
    end

    ////////////////////////////////////////
    // pair extraction
    ////////////////////////////////////////

    assign word_off = pc[OFFSET_W+1:2];

    // addressed word, then the odd word of the same aligned pair
    assign lo_word = line_sel[word_off];
    assign hi_word = line_sel[{word_off[OFFSET_W-1:1], 1'b1}];

    always_comb begin
        rsp.pc = pc;
        if (word_off[0]) begin
            // odd offset, single instruction
            rsp.instr        = {32'h0, lo_word};
            rsp.second_valid = 1'b0;
        end else begin
            rsp.instr        = {hi_word, lo_word};
            rsp.second_valid = 1'b1;
        end
    end

endmodule

/* icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////

    // instruction words held by one line
    localparam int WORDS_PER_LINE = 4;

    // word offset inside a line
    localparam int OFFSET_W = 2;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    ////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////

    // one request from the fetch stage
    typedef struct packed {
        logic [31:0] addr;
        // set for an index invalidate, clear for a fetch
        logic        inv;
    } fetch_req_t;

    // one fetch result
    typedef struct packed {
        logic [31:0] pc;
        // addressed word in the low half
        logic [63:0] instr;
        // upper word holds a real instruction
        logic        second_valid;
    } fetch_rsp_t;

    ////////////////////////////////////////
    // way lookup result
    ////////////////////////////////////////

    // presented by each way in the lookup cycle
    typedef struct packed {
        logic  hit;
        line_t line;
    } way_rd_t;

endpackage

/* icache_props.sv */
`timescale 1ns/10ps

module icache_props (
    input logic clk,
    input logic rst,
    input logic req_ready,
    input logic rsp_valid,
    input logic op_ack,
    input logic mem_req,
    input logic mem_valid
);

    ////////////////////////////////////////
    // memory handshake
    ////////////////////////////////////////

    // request level held until the line comes back
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req && !mem_valid) |=> mem_req
    ) else $error("mem_req dropped before mem_valid");

    // no new request while a refill is pending
    a_ready_low_in_refill: assert property (
        @(posedge clk) disable iff (rst)
        mem_req |-> !req_ready
    ) else $error("req_ready high while mem_req is high");

    ////////////////////////////////////////
    // pipeline strobes
    ////////////////////////////////////////

    a_rsp_ack_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(rsp_valid && op_ack)
    ) else $error("rsp_valid and op_ack high in the same cycle");

endmodule

bind icache_top icache_props u_props (
    .clk       (clk),
    .rst       (rst),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .op_ack    (op_ack),
    .mem_req   (mem_req),
    .mem_valid (mem_valid)
);

/* icache_top.sv */
`timescale 1ns/10ps

module icache_top #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    // fetch stage
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    output logic                   op_ack,
    // memory
    output logic                   mem_req,
    output logic [31:0]            mem_addr,
    input  logic                   mem_valid,
    input  icache_pkg::line_t      mem_line
);
    import icache_pkg::*;

    localparam int tag_width = 28 - index_width;

    way_rd_t                way0_rd;
    way_rd_t                way1_rd;

    logic                   rd_en;
    logic [index_width-1:0] rd_index;
    logic [tag_width-1:0]   cmp_tag;
    logic                   fill_we0;
    logic                   fill_we1;
    logic                   inv_we;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   wr_tag;
    logic                   sel_refill;
    logic [31:0]            pc;

    ////////////////////////////////////////
    // way banks
    ////////////////////////////////////////

    icache_way #(
        .index_width (index_width)
    ) u_way0 (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .cmp_tag   (cmp_tag),
        .fill_we   (fill_we0),
        .inv_we    (inv_we),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .fill_line (mem_line),
        .rd        (way0_rd)
    );

    icache_way #(
        .index_width (index_width)
    ) u_way1 (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .cmp_tag   (cmp_tag),
        .fill_we   (fill_we1),
        .inv_we    (inv_we),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .fill_line (mem_line),
        .rd        (way1_rd)
    );

    ////////////////////////////////////////
    // combiner and controller
    ////////////////////////////////////////

    icache_fetch_pack u_pack (
        .way0        (way0_rd),
        .way1        (way1_rd),
        .refill_line (mem_line),
        .sel_refill  (sel_refill),
        .pc          (pc),
        .rsp         (rsp)
    );

    icache_ctrl #(
        .index_width (index_width)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .op_ack     (op_ack),
        .hit0       (way0_rd.hit),
        .hit1       (way1_rd.hit),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .cmp_tag    (cmp_tag),
        .fill_we0   (fill_we0),
        .fill_we1   (fill_we1),
        .inv_we     (inv_we),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .sel_refill (sel_refill),
        .pc         (pc)
    );

endmodule

/* icache_way.sv */
`timescale 1ns/10ps

module icache_way #(
    parameter int index_width = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    // lookup read port
    input  logic                       rd_en,
    input  logic [index_width-1:0]     rd_index,
    input  logic [27-index_width:0]    cmp_tag,
    // refill and invalidate write port
    input  logic                       fill_we,
    input  logic                       inv_we,
    input  logic [index_width-1:0]     wr_index,
    input  logic [27-index_width:0]    wr_tag,
    input  icache_pkg::line_t          fill_line,
    output icache_pkg::way_rd_t        rd
);
    import icache_pkg::*;

    localparam int tag_width = 28 - index_width;
    localparam int num_sets = 1 << index_width;

    logic [tag_width-1:0] tag_mem [num_sets];
    line_t                line_mem [num_sets];

    logic [num_sets-1:0]  valid_q;
    logic [num_sets-1:0]  valid_d;

    logic [tag_width-1:0] rd_tag_q;
    line_t                rd_line_q;
    logic                 rd_valid_q;

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////

    // invalidate and fill never overlap, invalidate taken first anyway
    always_comb begin
        valid_d = valid_q;
        if (inv_we) begin
            valid_d[wr_index] = 1'b0;
        end else if (fill_we) begin
            valid_d[wr_index] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            valid_q <= valid_d;
            // read sees this cycle's write
            if (rd_en) begin
                rd_valid_q <= valid_d[rd_index];
            end
        end
    end

    ////////////////////////////////////////
    // tag and line arrays
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= fill_line;
        end
    end

    // synchronous read of the incoming set
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tag_q  <= tag_mem[rd_index];
            rd_line_q <= line_mem[rd_index];
        end
    end

    // tag compare against the registered request
    assign rd.hit  = rd_valid_q && (rd_tag_q == cmp_tag);
    assign rd.line = rd_line_q;

endmodule

/* tb_icache.sv */
`timescale 1ns/10ps

module tb_icache;
    import icache_pkg::*;

    localparam int clk_period = 4;
    localparam int reset_cycles = 5;
    localparam int sample_delay = 1;
    localparam int n_req = 400;
    localparam int num_sets = 16;
    localparam int max_mem_lat = 4;
    // lookup, refill, then the next acceptance
    localparam int worst_refill_cycles = max_mem_lat + 2;
    localparam int timeout_ns = (n_req * worst_refill_cycles * 2 + reset_cycles) * clk_period;

    logic        clk;
    logic        rst;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_ready;
    logic        rsp_valid;
    fetch_rsp_t  rsp;
    logic        op_ack;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    line_t       mem_line;

    logic [31:0] lfsr_q;
    logic        holding;
    int          issued;
    int          mem_wait;
    logic        mem_busy;

    // reference model of tags, valid bits and LRU
    logic        m_valid [2][num_sets];
    logic [23:0] m_tag [2][num_sets];
    logic        m_lru [num_sets];
    logic        lk_valid;
    fetch_req_t  lk_req;
    logic        refilling;
    logic [31:0] refill_addr;
    int          hit_count;
    int          miss_count;
    int          inv_count;
    int          evict_count;

    icache_top #(
        .index_width (4)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .op_ack    (op_ack),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_line  (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        report_failure("watchdog expired before all requests completed");
    end

    ////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_mem_addr(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // random source and memory contents
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end else begin
            return s >> 1;
        end
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a << 5) ^ 32'h9e37_79b9;
    endfunction

    function automatic line_t line_from_memory(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = mem_word(base + 32'(4 * w));
        end
        return l;
    endfunction

    function automatic logic [23:0] pool_tag(input logic [1:0] k);
        return {8'h4b, 6'h00, k, 8'h1e};
    endfunction

    // four sets in use with three tags each, so lines get evicted
    task automatic make_request(output fetch_req_t r);
        logic [31:0] b_set;
        logic [31:0] b_tag;
        logic [31:0] b_off;
        logic [31:0] b_inv;
        logic [1:0]  k;
        take_bits(2, b_set);
        take_bits(2, b_tag);
        take_bits(2, b_off);
        take_bits(3, b_inv);
        k = (b_tag[1:0] == 2'd3) ? 2'd1 : b_tag[1:0];
        r.addr = {pool_tag(k), b_set[1:0], b_set[1:0], b_off[1:0], 2'b00};
        r.inv  = (b_inv[2:0] == 3'd0);
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic int hit_way(input logic [31:0] addr);
        logic [3:0] idx;
        idx = addr[7:4];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == addr[31:8]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // even offset gives the aligned pair, odd offset a single word
    function automatic fetch_rsp_t expected_rsp(input logic [31:0] addr);
        fetch_rsp_t e;
        e.pc = addr;
        if (addr[2]) begin
            e.instr        = {32'h0, mem_word(addr)};
            e.second_valid = 1'b0;
        end else begin
            e.instr        = {mem_word(addr + 32'd4), mem_word(addr)};
            e.second_valid = 1'b1;
        end
        return e;
    endfunction

    task automatic drive_inputs();
        logic [31:0] lat;
        fetch_req_t  next;
        if (!holding && issued < n_req) begin
            make_request(next);
            req = next;
            holding = 1'b1;
            issued++;
        end
        req_valid = holding;
        // memory answers after 1 to 4 cycles
        mem_valid = 1'b0;
        if (mem_req && !mem_busy) begin
            take_bits(2, lat);
            mem_wait = 1 + int'(lat[1:0]);
            mem_busy = 1'b1;
        end
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_valid = 1'b1;
                mem_line = line_from_memory(mem_addr);
                mem_busy = 1'b0;
            end
        end
    endtask

    task automatic compare_and_step();
        logic [3:0] idx;
        logic [3:0] fill_idx;
        int         way;
        logic       lk_hit;
        logic       lk_inv;
        logic       fill;
        logic       victim;
        logic       exp_ready;
        idx = lk_req.addr[7:4];
        fill_idx = refill_addr[7:4];
        way = (lk_valid && !lk_req.inv) ? hit_way(lk_req.addr) : -1;
        lk_inv = lk_valid && lk_req.inv;
        lk_hit = lk_valid && !lk_req.inv && (way >= 0);
        fill = refilling && mem_valid;
        exp_ready = !(lk_valid && !lk_req.inv && !lk_hit) && !refilling;

        check_bit("req_ready", req_ready, exp_ready);
        check_bit("rsp_valid", rsp_valid, lk_hit || fill);
        check_bit("op_ack", op_ack, lk_inv);
        check_bit("mem_req", mem_req, refilling);
        if (refilling) begin
            check_mem_addr("mem_addr", mem_addr, {refill_addr[31:4], 4'h0});
        end
        if (lk_hit) begin
            check_rsp("rsp", rsp, expected_rsp(lk_req.addr));
        end
        if (fill) begin
            check_rsp("rsp", rsp, expected_rsp(refill_addr));
        end

        // state after the coming edge
        if (fill) begin
            victim = m_lru[fill_idx];
            if (m_valid[victim][fill_idx]) begin
                evict_count++;
            end
            m_valid[victim][fill_idx] = 1'b1;
            m_tag[victim][fill_idx] = refill_addr[31:8];
            m_lru[fill_idx] = !victim;
            refilling = 1'b0;
        end
        if (lk_inv) begin
            m_valid[0][idx] = 1'b0;
            m_valid[1][idx] = 1'b0;
            inv_count++;
        end else if (lk_hit) begin
            m_lru[idx] = (way == 0);
            hit_count++;
        end else if (lk_valid) begin
            refilling = 1'b1;
            refill_addr = lk_req.addr;
            miss_count++;
        end
        lk_valid = req_valid && exp_ready;
        if (lk_valid) begin
            lk_req = req;
            holding = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        mem_valid = 1'b0;
        mem_line = '0;
        lfsr_q = 32'h5f47;
        holding = 1'b0;
        issued = 0;
        mem_wait = 0;
        mem_busy = 1'b0;
        lk_valid = 1'b0;
        lk_req = '0;
        refilling = 1'b0;
        refill_addr = '0;
        hit_count = 0;
        miss_count = 0;
        inv_count = 0;
        evict_count = 0;
        for (int s = 0; s < num_sets; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_tag[0][s] = '0;
            m_tag[1][s] = '0;
            m_lru[s] = 1'b0;
        end

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle outputs right after reset
        #(sample_delay);
        check_bit("rsp_valid", rsp_valid, 1'b0);
        check_bit("op_ack", op_ack, 1'b0);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("req_ready", req_ready, 1'b1);

        while (issued < n_req || holding || lk_valid || refilling) begin
            @(negedge clk);
            drive_inputs();
            #(sample_delay);
            compare_and_step();
        end

        if (hit_count == 0 || miss_count == 0 || inv_count == 0 || evict_count == 0) begin
            report_failure($sformatf(
                "random run missed a case: %0d hits %0d misses %0d inv %0d evict",
                hit_count, miss_count, inv_count, evict_count));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
